// File: rtl/icache_pkg.sv
package icache_pkg;

  // the decoded address view is laid out for this geometry.
  // only the index width may vary, and then the array slices the raw view.
  localparam int DEF_OFFSET_W = 2;
  localparam int DEF_INDEX_W  = 4;
  localparam int DEF_TAG_W    = 32 - DEF_INDEX_W - DEF_OFFSET_W;

  // top address nibble at or above this is cacheable.
  localparam logic [3:0] CACHE_REGION_MIN = 4'h3;

  typedef struct packed {
    logic [DEF_TAG_W-1:0]    tag;
    logic [DEF_INDEX_W-1:0]  index;
    logic [DEF_OFFSET_W-1:0] offset; // byte within the word.
  } fetch_fields_t;

  typedef union packed {
    logic [31:0]   raw;
    fetch_fields_t f;
  } fetch_addr_u;

  // read address, fetch side and memory side.
  typedef struct packed {
    logic [31:0] addr;
  } ar_req_t;

  typedef struct packed {
    logic [31:0] data;
  } fetch_r_t;

  // one beat of the memory read channel.
  typedef struct packed {
    logic [63:0] data;
  } mem_r_t;

  // refill result written into the array.
  typedef struct packed {
    logic        wr;        // write strobe.
    fetch_addr_u addr;
    logic [31:0] word;
    logic        cacheable; // address inside the cacheable region.
  } fill_t;

  typedef logic [31:0] perf_cnt_t;

endpackage

// File: rtl/icache_array.sv
module icache_array
  import icache_pkg::*;
#(
  parameter int OFFSET_W = 2,
  parameter int INDEX_W  = 4
) (
  input  logic        clk,
  input  logic        rstn,
  input  fetch_addr_u lookup_addr,
  input  fill_t       fill,
  output logic        hit,
  output fetch_r_t    hit_word
);

  localparam int TAG_W = 32 - OFFSET_W - INDEX_W;
  localparam int ROW_N = 1 << INDEX_W;

  logic [ROW_N-1:0] row_valid;
  logic [TAG_W-1:0] row_tag  [ROW_N];
  logic [31:0]      row_data [ROW_N];

  logic [INDEX_W-1:0] rd_index;
  logic [TAG_W-1:0]   rd_tag;
  logic [INDEX_W-1:0] wr_index;
  logic [TAG_W-1:0]   wr_tag;
  logic               wr_en;

  generate
    if (OFFSET_W == DEF_OFFSET_W && INDEX_W == DEF_INDEX_W) begin : g_fields
      assign rd_index = lookup_addr.f.index;
      assign rd_tag   = lookup_addr.f.tag;
      assign wr_index = fill.addr.f.index;
      assign wr_tag   = fill.addr.f.tag;
    end else begin : g_raw
      // geometry differs from the union layout.
      assign rd_index = lookup_addr.raw[OFFSET_W+INDEX_W-1:OFFSET_W];
      assign rd_tag   = lookup_addr.raw[31:OFFSET_W+INDEX_W];
      assign wr_index = fill.addr.raw[OFFSET_W+INDEX_W-1:OFFSET_W];
      assign wr_tag   = fill.addr.raw[31:OFFSET_W+INDEX_W];
    end
  endgenerate

  assign wr_en = fill.wr & fill.cacheable; // uncached words pass through.

  assign hit           = row_valid[rd_index] & (row_tag[rd_index] == rd_tag);
  assign hit_word.data = row_data[rd_index];

  always_ff @(posedge clk) begin
    if (!rstn) begin
      row_valid <= '0;
    end else if (wr_en) begin
      row_valid[wr_index] <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (wr_en) begin
      row_tag[wr_index]  <= wr_tag;
      row_data[wr_index] <= fill.word;
    end
  end

endmodule

// File: rtl/icache_refill.sv
module icache_refill
  import icache_pkg::*;
(
  input  logic        clk,
  input  logic        rstn,
  input  logic        miss_start,
  input  fetch_addr_u miss_addr,
  output logic        mem_ar_valid,
  output ar_req_t     mem_ar,
  input  logic        mem_ar_ready,
  input  logic        mem_r_valid,
  input  mem_r_t      mem_r,
  output logic        mem_r_ready,
  output logic        refill_done,
  output fetch_r_t    refill_word,
  output fill_t       fill
);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_ADDR,
    ST_DATA
  } state_t;

  state_t      state;
  fetch_addr_u addr_q;
  logic [31:0] word_q;
  logic        done_q;
  logic [31:0] beat_word;
  logic        cacheable;

  assign mem_ar_valid = (state == ST_ADDR);
  assign mem_ar.addr  = addr_q.raw;
  assign mem_r_ready  = (state == ST_DATA);

  // bit 2 picks the word within the 64-bit beat.
  assign beat_word = addr_q.raw[2] ? mem_r.data[63:32] : mem_r.data[31:0];
  assign cacheable = (addr_q.raw[31:28] >= CACHE_REGION_MIN);

  always_ff @(posedge clk) begin
    if (!rstn) begin
      state  <= ST_IDLE;
      done_q <= 1'b0;
    end else begin
      done_q <= 1'b0;
      case (state)
        ST_IDLE: begin
          if (miss_start) begin
            state <= ST_ADDR;
          end
        end
        ST_ADDR: begin
          if (mem_ar_ready) begin
            state <= ST_DATA;
          end
        end
        ST_DATA: begin
          if (mem_r_valid) begin
            state  <= ST_IDLE;
            done_q <= 1'b1; // one-cycle pulse.
          end
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == ST_IDLE && miss_start) begin
      addr_q <= miss_addr;
    end
    if (mem_r_valid && mem_r_ready) begin
      word_q <= beat_word;
    end
  end

  assign refill_done      = done_q;
  assign refill_word.data = word_q;

  assign fill.wr        = done_q;
  assign fill.addr      = addr_q;
  assign fill.word      = word_q;
  assign fill.cacheable = cacheable;

endmodule

// File: rtl/icache_resp.sv
module icache_resp
  import icache_pkg::*;
(
  input  logic        clk,
  input  logic        rstn,
  input  logic        ar_valid,
  input  ar_req_t     ar,
  output logic        ar_ready,
  output logic        r_valid,
  output fetch_r_t    r,
  input  logic        r_ready,
  output fetch_addr_u lookup_addr,
  input  logic        hit,
  input  fetch_r_t    hit_word,
  output logic        miss_start,
  output fetch_addr_u miss_addr,
  input  logic        refill_done,
  input  fetch_r_t    refill_word,
  output perf_cnt_t   hit_count,
  output perf_cnt_t   miss_count
);

  logic        ar_hs;
  logic        r_hs;
  fetch_addr_u addr_q;
  logic        hit_start;
  logic        resp_hit;

  assign ar_hs = ar_valid & ar_ready;
  assign r_hs  = r_valid & r_ready;

  // incoming address while accepting, held address after.
  assign lookup_addr.raw = ar_hs ? ar.addr : addr_q.raw;
  assign miss_addr       = addr_q;

  always_ff @(posedge clk) begin
    if (!rstn) begin
      ar_ready   <= 1'b1;
      r_valid    <= 1'b0;
      miss_start <= 1'b0;
      hit_start  <= 1'b0;
      resp_hit   <= 1'b0;
    end else begin
      miss_start <= ar_hs & ~hit;
      hit_start  <= ar_hs & hit;
      if (ar_hs) begin
        ar_ready <= 1'b0; // one request in flight.
      end
      if (hit_start || refill_done) begin
        r_valid  <= 1'b1;
        resp_hit <= hit_start;
      end else if (r_hs) begin
        r_valid  <= 1'b0;
        ar_ready <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (ar_hs) begin
      addr_q.raw <= ar.addr;
    end
    if (hit_start) begin
      r <= hit_word;
    end else if (refill_done) begin
      r <= refill_word;
    end
  end

  // counted when the fetch unit takes the word.
  always_ff @(posedge clk) begin
    if (!rstn) begin
      hit_count  <= '0;
      miss_count <= '0;
    end else if (r_hs) begin
      if (resp_hit) begin
        hit_count <= hit_count + 32'd1;
      end else begin
        miss_count <= miss_count + 32'd1;
      end
    end
  end

endmodule

// File: rtl/icache_top.sv
module icache_top
  import icache_pkg::*;
#(
  parameter int OFFSET_W = 2,
  parameter int INDEX_W  = 4
) (
  input  logic      clk,
  input  logic      rstn,

  input  logic      ar_valid,
  input  ar_req_t   ar,
  output logic      ar_ready,
  output logic      r_valid,
  output fetch_r_t  r,
  input  logic      r_ready,

  output logic      mem_ar_valid,
  output ar_req_t   mem_ar,
  input  logic      mem_ar_ready,
  input  logic      mem_r_valid,
  input  mem_r_t    mem_r,
  output logic      mem_r_ready,

  output perf_cnt_t hit_count,
  output perf_cnt_t miss_count
);

  fetch_addr_u lookup_addr;
  logic        hit;
  fetch_r_t    hit_word;
  logic        miss_start;
  fetch_addr_u miss_addr;
  logic        refill_done;
  fetch_r_t    refill_word;
  fill_t       fill;

  icache_array #(
    .OFFSET_W (OFFSET_W),
    .INDEX_W  (INDEX_W)
  ) u_array (
    .clk         (clk),
    .rstn        (rstn),
    .lookup_addr (lookup_addr),
    .fill        (fill),
    .hit         (hit),
    .hit_word    (hit_word)
  );

  icache_refill u_refill (
    .clk          (clk),
    .rstn         (rstn),
    .miss_start   (miss_start),
    .miss_addr    (miss_addr),
    .mem_ar_valid (mem_ar_valid),
    .mem_ar       (mem_ar),
    .mem_ar_ready (mem_ar_ready),
    .mem_r_valid  (mem_r_valid),
    .mem_r        (mem_r),
    .mem_r_ready  (mem_r_ready),
    .refill_done  (refill_done),
    .refill_word  (refill_word),
    .fill         (fill)
  );

  icache_resp u_resp (
    .clk         (clk),
    .rstn        (rstn),
    .ar_valid    (ar_valid),
    .ar          (ar),
    .ar_ready    (ar_ready),
    .r_valid     (r_valid),
    .r           (r),
    .r_ready     (r_ready),
    .lookup_addr (lookup_addr),
    .hit         (hit),
    .hit_word    (hit_word),
    .miss_start  (miss_start),
    .miss_addr   (miss_addr),
    .refill_done (refill_done),
    .refill_word (refill_word),
    .hit_count   (hit_count),
    .miss_count  (miss_count)
  );

endmodule

// File: bench/clk_gen.sv
module clk_gen #(
  parameter int PERIOD       = 100,
  parameter int RESET_CYCLES = 10
) (
  output logic clk,
  output logic rstn
);

  initial begin
    clk = 1'b0;
    forever #(PERIOD / 2) clk = ~clk;
  end

  initial begin
    rstn = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    rstn <= 1'b1; // released on a rising edge.
  end

endmodule

// File: bench/mem_model.sv
module mem_model
  import icache_pkg::*;
#(
  parameter logic [31:0] SEED = 32'h77cf_a2ce
) (
  input  logic    clk,
  input  logic    rstn,
  input  logic    mem_ar_valid,
  input  ar_req_t mem_ar,
  output logic    mem_ar_ready,
  output logic    mem_r_valid,
  output mem_r_t  mem_r,
  input  logic    mem_r_ready
);

  logic [31:0] lcg_state;
  logic [31:0] addr_q;
  logic [1:0]  wait_cnt;
  logic        busy; // address taken and beat pending.

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  function automatic logic [1:0] delay_of(input logic [31:0] s);
    return s[29:28]; // upper bits give 0 to 3 cycles.
  endfunction

  // each half carries its own word address.
  function automatic logic [63:0] beat_of(input logic [31:0] a);
    logic [31:0] lo_addr;
    logic [31:0] hi_addr;
    lo_addr = {a[31:3], 3'b000};
    hi_addr = {a[31:3], 3'b100};
    return {hi_addr ^ 32'h5a5a_0000, lo_addr ^ 32'h5a5a_0000};
  endfunction

  initial begin
    mem_ar_ready = 1'b0;
    mem_r_valid  = 1'b0;
    mem_r        = '0;
  end

  always @(posedge clk) begin
    if (!rstn) begin
      lcg_state    <= lcg_next(SEED);
      mem_ar_ready <= 1'b0;
      mem_r_valid  <= 1'b0;
      busy         <= 1'b0;
      addr_q       <= '0;
      wait_cnt     <= delay_of(SEED);
    end else if (!busy) begin
      if (mem_ar_valid && mem_ar_ready) begin
        mem_ar_ready <= 1'b0;
        busy         <= 1'b1;
        addr_q       <= mem_ar.addr;
        wait_cnt     <= delay_of(lcg_state); // data delay.
        lcg_state    <= lcg_next(lcg_state);
      end else if (mem_ar_valid) begin
        if (wait_cnt == 2'd0) begin
          mem_ar_ready <= 1'b1;
        end else begin
          wait_cnt <= wait_cnt - 2'd1;
        end
      end
    end else if (mem_r_valid && mem_r_ready) begin
      mem_r_valid <= 1'b0;
      busy        <= 1'b0;
      wait_cnt    <= delay_of(lcg_state); // address delay of the next read.
      lcg_state   <= lcg_next(lcg_state);
    end else if (!mem_r_valid) begin
      if (wait_cnt == 2'd0) begin
        mem_r_valid <= 1'b1;
        mem_r.data  <= beat_of(addr_q);
      end else begin
        wait_cnt <= wait_cnt - 2'd1;
      end
    end
  end

endmodule

// File: bench/icache_tb.sv
module icache_tb
  import icache_pkg::*;
();

  localparam int WAIT_LIMIT  = 50;
  localparam int RESET_LIMIT = 40;

  typedef struct {
    string       name;
    logic [31:0] addr;
    int          stall;
    logic [31:0] data;
    logic        hit;
  } vector_t;

  logic      clk;
  logic      rstn;
  logic      ar_valid;
  ar_req_t   ar;
  logic      ar_ready;
  logic      r_valid;
  fetch_r_t  r;
  logic      r_ready;
  logic      mem_ar_valid;
  ar_req_t   mem_ar;
  logic      mem_ar_ready;
  logic      mem_r_valid;
  mem_r_t    mem_r;
  logic      mem_r_ready;
  perf_cnt_t hit_count;
  perf_cnt_t miss_count;

  vector_t   vecs[$];
  int        value_errors;
  int        other_errors;
  bit        aborted;
  perf_cnt_t exp_hits;
  perf_cnt_t exp_misses;
  int        k;
  int        n;

  clk_gen #(.PERIOD(100), .RESET_CYCLES(10)) u_clk (.clk(clk), .rstn(rstn));

  icache_top dut (.*);

  mem_model #(.SEED(32'h77cf_a2ce)) u_mem (.*);

  task automatic check_word(input string name, input fetch_r_t exp, input fetch_r_t act);
    if (act !== exp) begin
      value_errors++;
      $display("Error %s: expected %h, actual %h", name, exp.data, act.data);
    end
  endtask

  task automatic check_count(input string name, input perf_cnt_t exp, input perf_cnt_t act);
    if (act !== exp) begin
      value_errors++;
      $display("Error %s: expected %0d, actual %0d", name, exp, act);
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      value_errors++;
      $display("Error %s: expected %b, actual %b", name, exp, act);
    end
  endtask

  task automatic add_vec(input string name, input logic [31:0] addr, input int stall,
                         input logic [31:0] data, input logic hit);
    vector_t v;
    v.name  = name;
    v.addr  = addr;
    v.stall = stall;
    v.data  = data;
    v.hit   = hit;
    vecs.push_back(v);
  endtask

  // expected hits follow the line contents indexed by addr[5:2].
  task automatic load_table();
    add_vec("miss_first",      32'h3000_0010, 0, 32'h6a5a_0010, 1'b0);
    add_vec("hit_repeat",      32'h3000_0010, 0, 32'h6a5a_0010, 1'b1);
    add_vec("evict_a",         32'h3000_0018, 0, 32'h6a5a_0018, 1'b0);
    add_vec("evict_b",         32'h4000_0018, 1, 32'h1a5a_0018, 1'b0);
    add_vec("evict_a_back",    32'h3000_0018, 0, 32'h6a5a_0018, 1'b0);
    add_vec("evict_a_hit",     32'h3000_0018, 0, 32'h6a5a_0018, 1'b1);
    add_vec("odd_word",        32'h3000_0014, 0, 32'h6a5a_0014, 1'b0); // upper half.
    add_vec("odd_word_hit",    32'h3000_0014, 2, 32'h6a5a_0014, 1'b1);
    add_vec("first_kept",      32'h3000_0010, 0, 32'h6a5a_0010, 1'b1);
    add_vec("uncached",        32'h1000_0020, 0, 32'h4a5a_0020, 1'b0);
    add_vec("uncached_again",  32'h1000_0020, 0, 32'h4a5a_0020, 1'b0);
    add_vec("region_two",      32'h2000_0024, 0, 32'h7a5a_0024, 1'b0);
    add_vec("region_two_again", 32'h2000_0024, 1, 32'h7a5a_0024, 1'b0);
    add_vec("low_page",        32'h0000_000c, 0, 32'h5a5a_000c, 1'b0);
    add_vec("stall_miss",      32'h3000_0100, 5, 32'h6a5a_0100, 1'b0);
    add_vec("stall_hit",       32'h3000_0100, 3, 32'h6a5a_0100, 1'b1);
    add_vec("top_region",      32'hf000_0040, 2, 32'haa5a_0040, 1'b0); // evicts line 0.
    add_vec("top_region_hit",  32'hf000_0040, 0, 32'haa5a_0040, 1'b1);
  endtask

  task automatic run_fetch(input vector_t v);
    int       cnt;
    int       i;
    bit       mem_seen;
    bit       ready_early;
    fetch_r_t exp_word;
    exp_word.data = v.data;
    mem_seen      = 1'b0;
    ready_early   = 1'b0;
    ar_valid <= 1'b1;
    ar.addr  <= v.addr;
    cnt = 0;
    do begin
      @(posedge clk);
      cnt++;
    end while (!ar_ready && cnt < WAIT_LIMIT);
    if (!ar_ready) begin
      $display("%s: the request was never accepted", v.name);
      other_errors++;
      aborted = 1'b1;
      return;
    end
    ar_valid <= 1'b0;
    r_ready  <= (v.stall == 0);
    cnt = 0;
    do begin
      @(posedge clk);
      cnt++;
      if (mem_ar_valid) mem_seen = 1'b1;
      if (ar_ready) ready_early = 1'b1;
    end while (!r_valid && cnt < WAIT_LIMIT);
    if (!r_valid) begin
      $display("%s: no read response arrived", v.name);
      other_errors++;
      aborted = 1'b1;
      return;
    end
    check_word(v.name, exp_word, r);
    check_bit({v.name, " hit"}, v.hit, !mem_seen);
    if (ready_early) begin
      $display("%s: ar_ready rose before the response", v.name);
      other_errors++;
    end
    if (v.hit && cnt != 2) begin
      $display("%s: hit answered %0d cycles after the handshake", v.name, cnt - 1);
      other_errors++;
    end
    for (i = 0; i < v.stall; i++) begin
      if (i == v.stall - 1) r_ready <= 1'b1;
      @(posedge clk);
      check_bit({v.name, " r_valid held"}, 1'b1, r_valid);
      check_word({v.name, " r held"}, exp_word, r);
      check_bit({v.name, " ar_ready low"}, 1'b0, ar_ready);
    end
    r_ready <= 1'b0;
    if (v.hit) begin
      exp_hits = exp_hits + 32'd1;
    end else begin
      exp_misses = exp_misses + 32'd1;
    end
    @(posedge clk);
    check_count({v.name, " hit_count"}, exp_hits, hit_count);
    check_count({v.name, " miss_count"}, exp_misses, miss_count);
    check_bit({v.name, " r_valid done"}, 1'b0, r_valid);
    check_bit({v.name, " ar_ready back"}, 1'b1, ar_ready);
  endtask

  initial begin
    ar_valid     = 1'b0;
    ar           = '0;
    r_ready      = 1'b0;
    value_errors = 0;
    other_errors = 0;
    aborted      = 1'b0;
    exp_hits     = '0;
    exp_misses   = '0;
    load_table();
    n = 0;
    while (rstn !== 1'b1 && n < RESET_LIMIT) begin
      @(posedge clk);
      n++;
    end
    if (rstn !== 1'b1) begin
      $display("reset was never released");
      other_errors++;
      aborted = 1'b1;
    end else begin
      check_bit("reset r_valid", 1'b0, r_valid);
      check_bit("reset mem_ar_valid", 1'b0, mem_ar_valid);
      check_bit("reset mem_r_ready", 1'b0, mem_r_ready);
      check_bit("reset ar_ready", 1'b1, ar_ready);
      check_count("reset hit_count", '0, hit_count);
      check_count("reset miss_count", '0, miss_count);
    end
    for (k = 0; k < vecs.size() && !aborted; k++) begin
      run_fetch(vecs[k]);
    end
    $display("errors: %0d value, %0d other", value_errors, other_errors);
    if (value_errors == 0 && other_errors == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

// File: icache_top.f
rtl/icache_pkg.sv
rtl/icache_array.sv
rtl/icache_refill.sv
rtl/icache_resp.sv
rtl/icache_top.sv
bench/clk_gen.sv
bench/mem_model.sv
bench/icache_tb.sv

// File: run.sh
#!/bin/sh
# compile with verilator, run, then look for the pass line in the log
rm -f sim.log
verilator --binary --timing --top-module icache_tb -f icache_top.f -o icache_sim \
  && ./obj_dir/icache_sim > sim.log 2>&1 \
  || { echo "compile or simulation error"; cat sim.log 2>/dev/null; exit 1; }
cat sim.log
grep -qx "Everything OK" sim.log && echo "run passed" || { echo "run failed"; exit 1; }
